//--- Makefile
TOP = tb_csr_subsys

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sim.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation finished: PASS"

lint:
	verilator --lint-only -Wall +incdir+verilog --top-module csr_subsys_top \
		verilog/csr_pkg.sv verilog/csr_decode.sv verilog/csr_req_queue.sv \
		verilog/csr_file.sv verilog/csr_subsys_top.sv

clean:
	rm -rf obj_dir

//--- sim.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/csr_decode.sv
verilog/csr_req_queue.sv
verilog/csr_file.sv
verilog/csr_subsys_top.sv
test/tb_clock.sv
test/tb_csr_subsys.sv

//--- test/csr_stimulus.txt
// columns: inst pc rs1 | expected rdata trap redirect target (all hex)
// one instruction per line, responses expected in this order
340110F3 00000100 12345678 00000000 0 0 00000000
340020F3 00000104 FFFFFFFF 12345678 0 0 00000000
341110F3 00000108 00000ABC 00000000 0 0 00000000
341020F3 0000010C 00000000 00000ABC 0 0 00000000
340110F3 00000110 CAFEF00D 12345678 0 0 00000000
340020F3 00000114 00000000 CAFEF00D 0 0 00000000
300120F3 00000118 FFFFFFFF 00000000 0 0 00000000
300130F3 0000011C 00000080 00001888 0 0 00000000
300020F3 00000120 00000000 00001808 0 0 00000000
304110F3 00000124 FFFFFFFF 00000000 0 0 00000000
304070F3 00000128 FFFFFFFF 00000080 0 0 00000000
300470F3 0000012C 00000000 00001808 0 0 00000000
305110F3 00000130 00002007 00000000 0 0 00000000
305020F3 00000134 00000000 00002004 0 0 00000000
301020F3 00000138 00000000 40000100 0 0 00000000
301110F3 0000013C 00000000 40000100 0 0 00000000
F11020F3 00000140 00000000 00000000 0 0 00000000
F12020F3 00000144 00000000 00000001 0 0 00000000
F12110F3 00000148 0000FFFF 00000001 0 0 00000000
F12020F3 0000014C 00000000 00000001 0 0 00000000
F13020F3 00000150 00000000 00000000 0 0 00000000
F14020F3 00000154 00000000 00000000 0 0 00000000
7C0020F3 00000158 00000000 00000000 1 1 00002004
342020F3 0000015C 00000000 00000002 0 0 00000000
300460F3 00000160 00000000 00001800 0 0 00000000
00000073 00000164 00000000 00000000 1 1 00002004
341020F3 00000168 00000000 00000164 0 0 00000000
342020F3 0000016C 00000000 0000000B 0 0 00000000
300020F3 00000170 00000000 00001880 0 0 00000000
30200073 00000174 00000000 00000000 0 1 00000164
300020F3 00000178 00000000 00000088 0 0 00000000
00100073 0000017C 00000000 00000000 1 1 00002004
342020F3 00000180 00000000 00000003 0 0 00000000
341020F3 00000184 00000000 0000017C 0 0 00000000
B02020F3 00000188 00000000 00000022 0 0 00000000
B02110F3 0000018C 00000100 00000023 0 0 00000000
B02020F3 00000190 00000000 00000100 0 0 00000000

//--- test/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

`default_nettype wire

//--- test/tb_csr_subsys.sv
`default_nettype none

`include "csr_consts.svh"

module tb_csr_subsys;
    timeunit 1ns;
    timeprecision 100ps;

    import csr_pkg::*;

    localparam int CLK_PERIOD  = 10;
    // seven words per stimulus line
    localparam int COLS        = 7;
    localparam int MEM_AW      = 9;
    localparam int MEM_WORDS   = 1 << MEM_AW;
    localparam int MAX_ENTRIES = MEM_WORDS / COLS;

    logic             clk;
    logic             rst;
    logic             in_valid;
    logic             in_ready;
    logic [`XLEN-1:0] in_inst;
    logic [`XLEN-1:0] in_pc;
    logic [`XLEN-1:0] in_rs1;
    logic             resp_ready;
    logic             resp_valid;
    csr_resp_t        resp;

    logic [31:0]      stim_mem [MEM_WORDS];
    int               n;
    int               resp_idx;
    int               errors;
    int               seed;
    bit               loaded;
    bit               stall_seen;

    tb_clock u_tb_clock (
        .clk(clk)
    );

    csr_subsys_top u_csr_subsys_top (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_inst   (in_inst),
        .in_pc     (in_pc),
        .in_rs1    (in_rs1),
        .resp_ready(resp_ready),
        .resp_valid(resp_valid),
        .resp      (resp)
    );

    function automatic logic [31:0] stim_word(input int entry, input int col);
        return stim_mem[MEM_AW'(entry * COLS + col)];
    endfunction

    task automatic load_stimulus();
        for (int a = 0; a < MEM_WORDS; a++) begin
            stim_mem[MEM_AW'(a)] = ~32'(a);
        end
        $readmemh("test/csr_stimulus.txt", stim_mem);
        n = 0;
        // unread entries still hold the address pattern
        while (n < MAX_ENTRIES && stim_word(n, 0) !== ~32'(n * COLS)) begin
            n++;
        end
        assert (n > 0) else begin
            errors++;
            $display("no stimulus lines could be read from test/csr_stimulus.txt");
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_response();
        assert (resp_idx < n) else begin
            errors++;
            $display("extra response at %0t after all %0d expected ones", $time, n);
        end
        if (resp_idx < n) begin
            check_value("resp.rdata", resp.rdata, stim_word(resp_idx, 3));
            check_value("resp.trap", 32'(resp.trap), stim_word(resp_idx, 4));
            check_value("resp.redirect", 32'(resp.redirect), stim_word(resp_idx, 5));
            check_value("resp.target", resp.target, stim_word(resp_idx, 6));
            resp_idx++;
        end
    endtask

    task automatic drive_stimulus();
        int i;
        i = 0;
        while (i < n) begin
            @(negedge clk);
            if (in_ready) begin
                in_valid = 1'b1;
                in_inst  = stim_word(i, 0);
                in_pc    = stim_word(i, 1);
                in_rs1   = stim_word(i, 2);
                i++;
            end else begin
                in_valid   = 1'b0;
                stall_seen = 1'b1;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // random back-pressure, ready about 70% of cycles
    initial begin
        forever begin
            @(negedge clk);
            resp_ready = ({$random(seed)} % 10) < 7;
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (resp_valid) begin
                check_response();
            end
        end
    end

    initial begin
        wait (loaded);
        #((n * 50 + 10) * CLK_PERIOD);
        $display("watchdog expired at %0t, %0d of %0d responses received",
                 $time, resp_idx, n);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        seed       = 21;
        errors     = 0;
        resp_idx   = 0;
        stall_seen = 1'b0;
        loaded     = 1'b0;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_inst    = '0;
        in_pc      = '0;
        in_rs1     = '0;
        resp_ready = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        drive_stimulus();
        while (resp_idx < n) begin
            @(negedge clk);
        end
        // a stray response would show up within a few cycles
        repeat (10) @(negedge clk);
        assert (stall_seen) else begin
            errors++;
            $display("in_ready never dropped, the queue never filled");
        end
        $display("errors: %0d, responses checked: %0d of %0d", errors, resp_idx, n);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/csr_consts.svh
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

`define XLEN 32

// machine CSR addresses
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MISA      12'h301
`define CSR_ADDR_MIE       12'h304
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MSCRATCH  12'h340
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MIP       12'h344
`define CSR_ADDR_MINSTRET  12'hB02
`define CSR_ADDR_MVENDORID 12'hF11
`define CSR_ADDR_MARCHID   12'hF12
`define CSR_ADDR_MIMPID    12'hF13
`define CSR_ADDR_MHARTID   12'hF14

// MIE bit 3, MPIE bit 7, MPP bits 12:11
`define MSTATUS_WMASK 32'h0000_1888
`define MIE_WMASK     32'h0000_0080
`define MTVEC_WMASK   32'hFFFF_FFFC
// MXL = 1 (RV32), I extension only
`define MISA_VALUE    32'h4000_0100
`define MARCHID_VALUE 32'h0000_0001

`define CAUSE_ILLEGAL 32'd2
`define CAUSE_BREAK   32'd3
`define CAUSE_ECALL_M 32'd11

`define REQ_QUEUE_DEPTH 4

`endif

//--- verilog/csr_decode.sv
`default_nettype none

`include "csr_consts.svh"

module csr_decode #(
    parameter int DEPTH = `REQ_QUEUE_DEPTH
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    output logic                    in_ready,
    input  wire [`XLEN-1:0]         in_inst,
    input  wire [`XLEN-1:0]         in_pc,
    input  wire [`XLEN-1:0]         in_rs1,
    input  wire                     credit_return,
    output logic                    req_valid,
    output csr_pkg::csr_req_t       req
);
    import csr_pkg::*;

    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [CNT_W-1:0] credits;
    logic             accept;

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [4:0]       rs1_field;
    logic [4:0]       rd_field;
    logic [11:0]      funct12;

    csr_op_e          op;
    logic [`XLEN-1:0] operand;
    logic             write_en;

    assign opcode    = in_inst[6:0];
    assign rd_field  = in_inst[11:7];
    assign funct3    = in_inst[14:12];
    assign rs1_field = in_inst[19:15];
    assign funct12   = in_inst[31:20];

    assign in_ready = (credits != '0);
    assign accept   = in_valid & in_ready;

    always_comb begin
        op = OP_ILLEGAL;
        if (opcode == OPC_SYSTEM) begin
            case (funct3[1:0])
                2'b01: op = OP_CSRRW;
                2'b10: op = OP_CSRRS;
                2'b11: op = OP_CSRRC;
                default: begin
                    // privileged forms need rd and rs1 zero
                    if (funct3 == 3'b000 && rs1_field == 5'd0 && rd_field == 5'd0) begin
                        case (funct12)
                            12'h000: op = OP_ECALL;
                            12'h001: op = OP_EBREAK;
                            12'h302: op = OP_MRET;
                            default: op = OP_ILLEGAL;
                        endcase
                    end
                end
            endcase
        end
    end

    // funct3[2] selects the zimm forms
    assign operand = funct3[2] ? {{(`XLEN-5){1'b0}}, rs1_field} : in_rs1;

    always_comb begin
        case (op)
            OP_CSRRW: write_en = 1'b1;
            OP_CSRRS,
            OP_CSRRC: write_en = (rs1_field != 5'd0);
            default:  write_en = 1'b0;
        endcase
    end

    // one credit per send, one back per credit_return
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= CNT_W'(DEPTH);
        end else begin
            credits <= credits - CNT_W'(accept) + CNT_W'(credit_return);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid <= 1'b0;
        end else begin
            req_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req.op       <= op;
            req.addr     <= funct12;
            req.operand  <= operand;
            req.write_en <= write_en;
            req.pc       <= in_pc;
        end
    end

endmodule

`default_nettype wire

//--- verilog/csr_file.sv
`default_nettype none

`include "csr_consts.svh"

module csr_file (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     not_empty,
    input  wire csr_pkg::csr_req_t  head,
    input  wire                     resp_ready,
    output logic                    pop,
    output logic                    resp_valid,
    output csr_pkg::csr_resp_t      resp
);
    import csr_pkg::*;

    // mstatus fields
    localparam int MIE_BIT  = 3;
    localparam int MPIE_BIT = 7;
    localparam int MPP_LO   = 11;

    logic [`XLEN-1:0] mstatus;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] mie;
    logic [`XLEN-1:0] mscratch;
    logic [`XLEN-1:0] minstret;

    logic             is_csr_op;
    logic             addr_known;
    logic             trap_req;
    logic             ret_req;
    logic             csr_write;
    logic [`XLEN-1:0] old_val;
    logic [`XLEN-1:0] new_val;
    logic [`XLEN-1:0] cause;

    assign pop = not_empty & resp_ready;

    // read side, also flags unmapped addresses
    always_comb begin
        addr_known = 1'b1;
        old_val    = '0;
        case (head.addr)
            `CSR_ADDR_MSTATUS:   old_val = mstatus;
            `CSR_ADDR_MISA:      old_val = `MISA_VALUE;
            `CSR_ADDR_MIE:       old_val = mie;
            `CSR_ADDR_MTVEC:     old_val = mtvec;
            `CSR_ADDR_MSCRATCH:  old_val = mscratch;
            `CSR_ADDR_MEPC:      old_val = mepc;
            `CSR_ADDR_MCAUSE:    old_val = mcause;
            `CSR_ADDR_MIP:       old_val = '0;
            `CSR_ADDR_MINSTRET:  old_val = minstret;
            `CSR_ADDR_MVENDORID: old_val = '0;
            `CSR_ADDR_MARCHID:   old_val = `MARCHID_VALUE;
            `CSR_ADDR_MIMPID:    old_val = '0;
            `CSR_ADDR_MHARTID:   old_val = '0;
            default:             addr_known = 1'b0;
        endcase
    end

    assign is_csr_op = (head.op == OP_CSRRW) || (head.op == OP_CSRRS) ||
                       (head.op == OP_CSRRC);
    assign ret_req   = (head.op == OP_MRET);
    assign trap_req  = (head.op == OP_ECALL) || (head.op == OP_EBREAK) ||
                       (head.op == OP_ILLEGAL) || (is_csr_op && !addr_known);
    assign csr_write = is_csr_op & addr_known & head.write_en;

    always_comb begin
        case (head.op)
            OP_CSRRS: new_val = old_val | head.operand;
            OP_CSRRC: new_val = old_val & ~head.operand;
            default:  new_val = head.operand;
        endcase
    end

    always_comb begin
        case (head.op)
            OP_ECALL:  cause = `CAUSE_ECALL_M;
            OP_EBREAK: cause = `CAUSE_BREAK;
            default:   cause = `CAUSE_ILLEGAL;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus  <= '0;
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mie      <= '0;
            mscratch <= '0;
        end else if (pop) begin
            if (csr_write) begin
                // read-only and minstret addresses fall to default
                case (head.addr)
                    `CSR_ADDR_MSTATUS:  mstatus  <= new_val & `MSTATUS_WMASK;
                    `CSR_ADDR_MTVEC:    mtvec    <= new_val & `MTVEC_WMASK;
                    `CSR_ADDR_MEPC:     mepc     <= new_val;
                    `CSR_ADDR_MCAUSE:   mcause   <= new_val;
                    `CSR_ADDR_MIE:      mie      <= new_val & `MIE_WMASK;
                    `CSR_ADDR_MSCRATCH: mscratch <= new_val;
                    default: ;
                endcase
            end else if (trap_req) begin
                mepc                       <= head.pc;
                mcause                     <= cause;
                mstatus[MPIE_BIT]          <= mstatus[MIE_BIT];
                mstatus[MIE_BIT]           <= 1'b0;
                mstatus[MPP_LO+1:MPP_LO]   <= 2'b11;
            end else if (ret_req) begin
                mstatus[MIE_BIT]           <= mstatus[MPIE_BIT];
                mstatus[MPIE_BIT]          <= 1'b1;
                mstatus[MPP_LO+1:MPP_LO]   <= 2'b00;
            end
        end
    end

    // counts every popped request, trapped ones included
    always_ff @(posedge clk) begin
        if (rst) begin
            minstret <= '0;
        end else if (pop) begin
            if (csr_write && head.addr == `CSR_ADDR_MINSTRET) begin
                minstret <= new_val;
            end else begin
                minstret <= minstret + `XLEN'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            resp.rdata    <= is_csr_op ? old_val : '0;
            resp.trap     <= trap_req;
            resp.redirect <= trap_req | ret_req;
            if (trap_req) begin
                resp.target <= mtvec;
            end else if (ret_req) begin
                resp.target <= mepc;
            end else begin
                resp.target <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/csr_pkg.sv
`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

    // operations handed from decoder to CSR file
    typedef enum logic [2:0] {
        OP_CSRRW   = 3'd0,
        OP_CSRRS   = 3'd1,
        OP_CSRRC   = 3'd2,
        OP_ECALL   = 3'd3,
        OP_EBREAK  = 3'd4,
        OP_MRET    = 3'd5,
        OP_ILLEGAL = 3'd6
    } csr_op_e;

    typedef struct packed {
        csr_op_e           op;
        logic [11:0]       addr;
        // rs1 value or zero-extended zimm
        logic [`XLEN-1:0]  operand;
        logic              write_en;
        logic [`XLEN-1:0]  pc;
    } csr_req_t;

    typedef struct packed {
        // value before the update
        logic [`XLEN-1:0]  rdata;
        logic              trap;
        logic              redirect;
        logic [`XLEN-1:0]  target;
    } csr_resp_t;

endpackage

`default_nettype wire

//--- verilog/csr_req_queue.sv
`default_nettype none

`include "csr_consts.svh"

module csr_req_queue #(
    parameter int DEPTH = `REQ_QUEUE_DEPTH
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     req_valid,
    input  wire csr_pkg::csr_req_t  req,
    input  wire                     pop,
    output logic                    not_empty,
    output csr_pkg::csr_req_t       head,
    output logic                    credit_return
);
    import csr_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    csr_req_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // wrap at DEPTH, which need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    assign not_empty = (count != '0);
    assign head      = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            credit_return <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count         <= count + CNT_W'(req_valid) - CNT_W'(pop);
            credit_return <= pop;
        end
    end

endmodule

`default_nettype wire

//--- verilog/csr_subsys_top.sv
`default_nettype none

`include "csr_consts.svh"

module csr_subsys_top (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     in_valid,
    output logic                    in_ready,
    input  wire [`XLEN-1:0]         in_inst,
    input  wire [`XLEN-1:0]         in_pc,
    input  wire [`XLEN-1:0]         in_rs1,
    input  wire                     resp_ready,
    output logic                    resp_valid,
    output csr_pkg::csr_resp_t      resp
);
    import csr_pkg::*;

    logic     req_valid;
    csr_req_t req;
    logic     credit_return;
    logic     not_empty;
    csr_req_t head;
    logic     pop;

    csr_decode #(
        .DEPTH(`REQ_QUEUE_DEPTH)
    ) u_csr_decode (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .in_ready     (in_ready),
        .in_inst      (in_inst),
        .in_pc        (in_pc),
        .in_rs1       (in_rs1),
        .credit_return(credit_return),
        .req_valid    (req_valid),
        .req          (req)
    );

    csr_req_queue #(
        .DEPTH(`REQ_QUEUE_DEPTH)
    ) u_csr_req_queue (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .pop          (pop),
        .not_empty    (not_empty),
        .head         (head),
        .credit_return(credit_return)
    );

    csr_file u_csr_file (
        .clk       (clk),
        .rst       (rst),
        .not_empty (not_empty),
        .head      (head),
        .resp_ready(resp_ready),
        .pop       (pop),
        .resp_valid(resp_valid),
        .resp      (resp)
    );

endmodule

`default_nettype wire
